/* logic/rc4_consts.svh */
`ifndef RC4_CONSTS_SVH
`define RC4_CONSTS_SVH

// --------------------------------------------------
// RC4 sizing constants
// --------------------------------------------------

// Number of bytes in the state array, one per possible byte value.
`define RC4_N 256

// Length of the secret key in bytes.
`define RC4_KEY_BYTES 3

// Number of bytes in one encrypted message.
`define RC4_MSG_LEN 32

// Width of a message index, enough to count RC4_MSG_LEN bytes.
`define RC4_MSG_AW 5

`endif

/* logic/rc4_pkg.sv */
`include "rc4_consts.svh"

package rc4_pkg;

	// --------------------------------------------------
	// Basic scalar types
	// --------------------------------------------------

	typedef logic [7:0] byte_t;                          // One data byte of state or message.
	typedef logic [`RC4_MSG_AW-1:0] msg_idx_t;           // Position of a byte in the message.

	// The secret key arrives as one word but the scheduler walks it bytewise.
	typedef union packed {
		logic [8*`RC4_KEY_BYTES-1:0] word;               // Whole key as seen at the port.
		byte_t [0:`RC4_KEY_BYTES-1] bytes;               // Byte 0 is the most significant.
	} secret_key_u;

	// --------------------------------------------------
	// Bundles between blocks
	// --------------------------------------------------

	// A single access to the state memory.
	typedef struct packed {
		logic valid;                                     // Request present this cycle.
		logic we;                                        // High for a write, low for a read.
		byte_t addr;                                     // State array position.
		byte_t wdata;                                    // Byte written when we is high.
	} sbox_req_t;

	// One keystream byte tagged with the message position it belongs to.
	typedef struct packed {
		logic valid;                                     // Single cycle strobe.
		msg_idx_t idx;                                   // Message position.
		byte_t data;                                     // Keystream byte.
	} ks_byte_t;

	// One recovered plaintext byte.
	typedef struct packed {
		logic valid;                                     // Single cycle strobe.
		msg_idx_t idx;                                   // Message position.
		byte_t data;                                     // Plaintext byte.
	} pt_byte_t;

endpackage

/* logic/sbox_ram.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module sbox_ram (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               ksa_done_i,   // Low gives the port to the scheduler.
	input  rc4_pkg::sbox_req_t ksa_req_i,
	input  rc4_pkg::sbox_req_t gen_req_i,
	output rc4_pkg::byte_t     rd_data_o
);

	// --------------------------------------------------
	// Storage and owner select
	// --------------------------------------------------

	rc4_pkg::byte_t mem [`RC4_N];                    // The RC4 state permutation.
	rc4_pkg::sbox_req_t req;                         // Request of the current owner.
	rc4_pkg::byte_t rd_q1;                           // First read stage, the array output.
	rc4_pkg::byte_t rd_q2;                           // Second read stage, drives the port.

	// Only one requester is active at a time, so a plain mux is enough.
	always_comb begin
		if (ksa_done_i) begin
			req = gen_req_i;                         // Keystream phase owns the memory.
		end else begin
			req = ksa_req_i;                         // Init and scheduling own it.
		end
	end

	// Writes land at the edge that accepts them.
	always_ff @(posedge clk) begin
		if (req.valid && req.we) begin
			mem[req.addr] <= req.wdata;              // Store the byte.
		end
	end

	// --------------------------------------------------
	// Two-stage read pipeline
	// --------------------------------------------------

	// The first stage only moves on a read, so the data holds until the next one.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_q1 <= '0;
			rd_q2 <= '0;
		end else begin
			if (req.valid && !req.we) begin
				rd_q1 <= mem[req.addr];              // Sample the addressed byte.
			end
			rd_q2 <= rd_q1;                          // Second cycle of latency.
		end
	end

	assign rd_data_o = rd_q2;                        // Valid two cycles after the read.

endmodule

/* logic/ksa_ctrl.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module ksa_ctrl (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start_i,
	input  rc4_pkg::secret_key_u key_i,
	input  rc4_pkg::byte_t       rd_data_i,
	output rc4_pkg::sbox_req_t   req_o,
	output logic                 done_o
);

	typedef enum logic [3:0] {
		s_idle, s_init,
		s_rd_i, s_wt_i1, s_wt_i2, s_sv_i,
		s_rd_j, s_wt_j1, s_wt_j2, s_sv_j,
		s_wr_i, s_wr_j
	} state_t;

	state_t state;
	rc4_pkg::byte_t i;                               // Loop index, also the init value.
	rc4_pkg::byte_t j;                               // Running swap partner index.
	logic [1:0] key_idx;                             // Tracks i mod 3 without a divider.
	rc4_pkg::secret_key_u key_q;                     // Key held for the whole run.
	rc4_pkg::byte_t data_i;                          // S[i] saved before the swap.
	rc4_pkg::byte_t data_j;                          // S[j] saved before the swap.

	// --------------------------------------------------
	// Control FSM
	// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state   <= s_idle;
			i       <= '0;
			j       <= '0;
			key_idx <= '0;
			done_o  <= 1'b0;
		end else begin
			case (state)
				s_idle: if (start_i) begin
					i       <= '0;
					j       <= '0;
					key_idx <= '0;
					done_o  <= 1'b0;                 // Hands the memory back to this block.
					state   <= s_init;
				end
				s_init: begin
					i <= i + 8'd1;                   // Wraps to zero for the swap loop.
					if (i == 8'(`RC4_N - 1)) state <= s_rd_i;
				end
				s_rd_i:  state <= s_wt_i1;
				s_wt_i1: state <= s_wt_i2;
				s_wt_i2: state <= s_sv_i;
				s_sv_i: begin
					j     <= j + rd_data_i + key_q.bytes[key_idx];  // j += S[i] + key[i mod 3].
					state <= s_rd_j;
				end
				s_rd_j:  state <= s_wt_j1;
				s_wt_j1: state <= s_wt_j2;
				s_wt_j2: state <= s_sv_j;
				s_sv_j:  state <= s_wr_i;
				s_wr_i:  state <= s_wr_j;
				s_wr_j: begin
					i <= i + 8'd1;
					if (key_idx == 2'(`RC4_KEY_BYTES - 1)) key_idx <= '0;
					else key_idx <= key_idx + 2'd1;
					if (i == 8'(`RC4_N - 1)) begin
						done_o <= 1'b1;              // Last swap accepted at this edge.
						state  <= s_idle;
					end else begin
						state <= s_rd_i;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Payload captures, no control meaning.
	always_ff @(posedge clk) begin
		if (state == s_idle && start_i) key_q.word <= key_i.word;  // Latch the key.
		if (state == s_sv_i) data_i <= rd_data_i;
		if (state == s_sv_j) data_j <= rd_data_i;
	end

	// --------------------------------------------------
	// Memory requests
	// --------------------------------------------------

	always_comb begin
		req_o = '0;
		case (state)
			s_init: req_o = '{valid: 1'b1, we: 1'b1, addr: i, wdata: i};   // Identity fill.
			s_rd_i: req_o = '{valid: 1'b1, we: 1'b0, addr: i, wdata: '0};
			s_rd_j: req_o = '{valid: 1'b1, we: 1'b0, addr: j, wdata: '0};
			s_wr_i: req_o = '{valid: 1'b1, we: 1'b1, addr: i, wdata: data_j}; // S[i] = old S[j].
			s_wr_j: req_o = '{valid: 1'b1, we: 1'b1, addr: j, wdata: data_i}; // S[j] = old S[i].
			default: req_o = '0;
		endcase
	end

endmodule

/* logic/keystream_gen.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module keystream_gen (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               start_i,      // Scheduler done level.
	input  rc4_pkg::byte_t     rd_data_i,
	output rc4_pkg::sbox_req_t req_o,
	output rc4_pkg::ks_byte_t  ks_o
);

	typedef enum logic [3:0] {
		s_idle,
		s_rd_i, s_wt_i1, s_wt_i2, s_sv_i,
		s_rd_j, s_wt_j1, s_wt_j2, s_sv_j,
		s_wr_i, s_wr_j,
		s_rd_t, s_wt_t1, s_wt_t2, s_sv_t
	} state_t;

	state_t state;
	logic start_q;                                   // Previous start level for edge detect.
	logic start_rise;
	rc4_pkg::byte_t i;                               // Output loop index i.
	rc4_pkg::byte_t j;                               // Output loop index j.
	rc4_pkg::byte_t i_inc;
	rc4_pkg::msg_idx_t k;                            // Message byte being produced.
	rc4_pkg::byte_t s_i;                             // Saved S[i].
	rc4_pkg::byte_t s_j;                             // Saved S[j].

	assign start_rise = start_i && !start_q;        // Scheduling just finished.
	assign i_inc = i + 8'd1;

	// --------------------------------------------------
	// Output loop FSM
	// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state   <= s_idle;
			start_q <= 1'b0;
			i       <= '0;
			j       <= '0;
			k       <= '0;
			ks_o    <= '0;
		end else begin
			start_q    <= start_i;
			ks_o.valid <= 1'b0;                      // Strobe lasts one cycle.
			case (state)
				s_idle: if (start_rise) begin
					i     <= '0;
					j     <= '0;
					k     <= '0;
					state <= s_rd_i;
				end
				s_rd_i: begin
					i     <= i_inc;                  // Step i before reading S[i].
					state <= s_wt_i1;
				end
				s_wt_i1: state <= s_wt_i2;
				s_wt_i2: state <= s_sv_i;
				s_sv_i: begin
					j     <= j + rd_data_i;          // j += S[i].
					state <= s_rd_j;
				end
				s_rd_j:  state <= s_wt_j1;
				s_wt_j1: state <= s_wt_j2;
				s_wt_j2: state <= s_sv_j;
				s_sv_j:  state <= s_wr_i;
				s_wr_i:  state <= s_wr_j;
				s_wr_j:  state <= s_rd_t;
				s_rd_t:  state <= s_wt_t1;
				s_wt_t1: state <= s_wt_t2;
				s_wt_t2: state <= s_sv_t;
				s_sv_t: begin
					ks_o.valid <= 1'b1;
					ks_o.idx   <= k;
					ks_o.data  <= rd_data_i;         // S[S[i] + S[j]].
					k          <= k + 1'b1;
					if (k == rc4_pkg::msg_idx_t'(`RC4_MSG_LEN - 1)) state <= s_idle;
					else state <= s_rd_i;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_sv_i) s_i <= rd_data_i;
		if (state == s_sv_j) s_j <= rd_data_i;
	end

	// --------------------------------------------------
	// Memory requests
	// --------------------------------------------------

	always_comb begin
		req_o = '0;
		case (state)
			s_rd_i: req_o = '{valid: 1'b1, we: 1'b0, addr: i_inc, wdata: '0};
			s_rd_j: req_o = '{valid: 1'b1, we: 1'b0, addr: j, wdata: '0};
			s_wr_i: req_o = '{valid: 1'b1, we: 1'b1, addr: i, wdata: s_j};  // Swap, first half.
			s_wr_j: req_o = '{valid: 1'b1, we: 1'b1, addr: j, wdata: s_i};  // Swap, second half.
			s_rd_t: req_o = '{valid: 1'b1, we: 1'b0, addr: s_i + s_j, wdata: '0};
			default: req_o = '0;
		endcase
	end

endmodule

/* logic/cipher_store.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module cipher_store (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              load_i,
	input  rc4_pkg::msg_idx_t load_idx_i,
	input  rc4_pkg::byte_t    load_data_i,
	input  logic              busy_i,        // A run is in progress.
	input  rc4_pkg::ks_byte_t ks_i,
	output rc4_pkg::byte_t    ct_o,
	output rc4_pkg::ks_byte_t ks_o
);

	rc4_pkg::byte_t mem [`RC4_MSG_LEN];              // Ciphertext of the current message.

	// --------------------------------------------------
	// Load port and read by keystream index
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (load_i && !busy_i) begin
			mem[load_idx_i] <= load_data_i;          // Loads during a run are dropped.
		end
		if (ks_i.valid) begin
			ct_o <= mem[ks_i.idx];                   // Lines up with the delayed keystream.
		end
	end

	// Keystream copy delayed by the same cycle as the ciphertext read.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ks_o <= '0;
		end else begin
			ks_o <= ks_i;
		end
	end

endmodule

/* logic/plain_combine.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module plain_combine (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              start_i,
	input  rc4_pkg::ks_byte_t ks_i,
	input  rc4_pkg::byte_t    ct_i,
	output rc4_pkg::pt_byte_t pt_o,
	output logic              done_o,
	output logic              busy_o         // High from start until the last byte.
);

	rc4_pkg::msg_idx_t cnt;                          // Plaintext bytes delivered so far.

	// --------------------------------------------------
	// XOR stage and completion tracking
	// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pt_o   <= '0;
			cnt    <= '0;
			done_o <= 1'b0;
			busy_o <= 1'b0;
		end else begin
			pt_o.valid <= ks_i.valid;
			pt_o.idx   <= ks_i.idx;
			pt_o.data  <= ks_i.data ^ ct_i;          // RC4 decrypt is a plain XOR.
			if (start_i && !busy_o) begin
				busy_o <= 1'b1;                      // New run, loads now locked out.
				done_o <= 1'b0;
				cnt    <= '0;
			end else if (pt_o.valid) begin
				cnt <= cnt + 1'b1;
				if (cnt == rc4_pkg::msg_idx_t'(`RC4_MSG_LEN - 1)) begin
					done_o <= 1'b1;                  // One cycle after the last strobe.
					busy_o <= 1'b0;
				end
			end
		end
	end

endmodule

/* logic/rc4_top.sv */
`timescale 1ns/10ps

module rc4_top (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start_i,
	input  rc4_pkg::secret_key_u key_i,
	input  logic                 load_i,
	input  rc4_pkg::msg_idx_t    load_idx_i,
	input  rc4_pkg::byte_t       load_data_i,
	output rc4_pkg::pt_byte_t    pt_o,
	output logic                 done_o
);

	// --------------------------------------------------
	// Internal wiring
	// --------------------------------------------------

	rc4_pkg::sbox_req_t ksa_req;                     // Scheduler side of the memory.
	rc4_pkg::sbox_req_t gen_req;                     // Generator side of the memory.
	rc4_pkg::byte_t     rd_data;                     // Shared read data.
	logic               ksa_done;                    // Also the memory owner select.
	logic               busy;                        // Run in progress.
	rc4_pkg::ks_byte_t  ks_raw;                      // Keystream from the generator.
	rc4_pkg::ks_byte_t  ks_dly;                      // Keystream aligned with ciphertext.
	rc4_pkg::byte_t     ct_byte;                     // Ciphertext for the aligned index.

	sbox_ram u_sbox_ram (
		.clk        (clk),
		.reset_n    (reset_n),
		.ksa_done_i (ksa_done),
		.ksa_req_i  (ksa_req),
		.gen_req_i  (gen_req),
		.rd_data_o  (rd_data)
	);

	ksa_ctrl u_ksa_ctrl (
		.clk       (clk),
		.reset_n   (reset_n),
		.start_i   (start_i),
		.key_i     (key_i),
		.rd_data_i (rd_data),
		.req_o     (ksa_req),
		.done_o    (ksa_done)
	);

	keystream_gen u_keystream_gen (
		.clk       (clk),
		.reset_n   (reset_n),
		.start_i   (ksa_done),
		.rd_data_i (rd_data),
		.req_o     (gen_req),
		.ks_o      (ks_raw)
	);

	cipher_store u_cipher_store (
		.clk         (clk),
		.reset_n     (reset_n),
		.load_i      (load_i),
		.load_idx_i  (load_idx_i),
		.load_data_i (load_data_i),
		.busy_i      (busy),
		.ks_i        (ks_raw),
		.ct_o        (ct_byte),
		.ks_o        (ks_dly)
	);

	plain_combine u_plain_combine (
		.clk     (clk),
		.reset_n (reset_n),
		.start_i (start_i),
		.ks_i    (ks_dly),
		.ct_i    (ct_byte),
		.pt_o    (pt_o),
		.done_o  (done_o),
		.busy_o  (busy)
	);

endmodule

/* verif/rc4_assert.sv */
`timescale 1ns/10ps

module rc4_assert (
	input logic               clk,
	input logic               reset_n,
	input logic               start_i,
	input logic               ksa_done_i,      // Memory owner select.
	input rc4_pkg::sbox_req_t ksa_req_i,
	input rc4_pkg::sbox_req_t gen_req_i,
	input rc4_pkg::ks_byte_t  ks_i,
	input rc4_pkg::pt_byte_t  pt_i
);

	int fail_cnt = 0;                                // Number of failed checks so far.

	// --------------------------------------------------
	// Memory ownership and strobe rules
	// --------------------------------------------------

	a_ksa_owner: assert property (@(posedge clk) disable iff (!reset_n)
		ksa_done_i |-> !(ksa_req_i.valid && ksa_req_i.we))
		else begin
			fail_cnt++;
			$error("Scheduler wrote while the generator owns the state memory.");
		end
	a_gen_owner: assert property (@(posedge clk) disable iff (!reset_n)
		!ksa_done_i |-> !(gen_req_i.valid && gen_req_i.we))
		else begin
			fail_cnt++;
			$error("Generator wrote while the scheduler owns the state memory.");
		end
	a_done_hold: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(ksa_done_i) |-> $past(start_i))
		else begin
			fail_cnt++;
			$error("ksa_done fell without a start.");
		end
	a_ks_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		ks_i.valid |=> !ks_i.valid)
		else begin
			fail_cnt++;
			$error("Keystream valid lasted more than one cycle.");
		end
	a_pt_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		pt_i.valid |=> !pt_i.valid)
		else begin
			fail_cnt++;
			$error("Plaintext valid lasted more than one cycle.");
		end

endmodule

bind rc4_top rc4_assert u_rc4_assert (
	.clk        (clk),
	.reset_n    (reset_n),
	.start_i    (start_i),
	.ksa_done_i (ksa_done),
	.ksa_req_i  (ksa_req),
	.gen_req_i  (gen_req),
	.ks_i       (ks_raw),
	.pt_i       (pt_o)
);

/* verif/rc4_tb.sv */
`timescale 1ns/10ps
`include "rc4_consts.svh"

module rc4_tb;

	localparam int max_cases = 3;                        // Lines in the case file.
	localparam int msg_bits  = 8 * `RC4_MSG_LEN;

	logic clk, reset_n, start_i, load_i, done_o;
	rc4_pkg::secret_key_u key_i;
	rc4_pkg::msg_idx_t load_idx_i;
	rc4_pkg::byte_t load_data_i;
	rc4_pkg::pt_byte_t pt_o;
	logic [24+msg_bits-1:0] cases [max_cases];           // Key followed by plaintext, byte 0 leftmost.
	logic [msg_bits-1:0] ks_ref;                         // Keystream for the published vector.
	int n_cases, n_pass, errors, cycles, cycle_limit;

	rc4_top uut (.*);

	always #5 clk = ~clk;                                // 10 ns period.

	// Watchdog whose limit is set once the number of cases is known.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Reference model and compare tasks
	// --------------------------------------------------

	// Standard RC4 keystream for one message.
	function automatic logic [msg_bits-1:0] rc4_keystream(input logic [23:0] key);
		logic [7:0] s [256];
		logic [7:0] i;
		logic [7:0] j;
		logic [7:0] t;
		logic [msg_bits-1:0] ks;
		for (int n = 0; n < 256; n++) s[n] = 8'(n);      // Identity permutation.
		j = 0;
		for (int n = 0; n < 256; n++) begin
			j = j + s[n] + key[23 - 8 * (n % 3) -: 8];  // Key byte 0 is the top byte.
			t = s[n];
			s[n] = s[j];
			s[j] = t;
		end
		i = 0;
		j = 0;
		for (int n = 0; n < `RC4_MSG_LEN; n++) begin
			i = i + 8'd1;
			j = j + s[i];
			t = s[i];
			s[i] = s[j];
			s[j] = t;
			t = s[i] + s[j];                             // Wraps modulo 256.
			ks[msg_bits - 1 - 8 * n -: 8] = s[t];
		end
		return ks;
	endfunction

	task automatic check_pt(input rc4_pkg::pt_byte_t exp, input rc4_pkg::pt_byte_t act);
		if (act !== exp) begin
			$display("Error at %0t: pt_o expected %b/%0d/%h, got %b/%0d/%h", $time,
				exp.valid, exp.idx, exp.data, act.valid, act.idx, act.data);
			errors++;
		end
	endtask

	task automatic check_done(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error at %0t: done_o expected %b, got %b", $time, exp, act);
			errors++;
		end
	endtask

	// Quiet window in which done_o must hold its level and no strobe may appear.
	task automatic hold_idle(input logic exp_done);
		repeat (20) begin
			@(negedge clk);
			check_done(exp_done, done_o);
			if (pt_o.valid) begin
				$display("A plaintext strobe appeared while no run was active.");
				errors++;
			end
		end
	endtask

	task automatic run_case(input int c);
		rc4_pkg::secret_key_u key;
		rc4_pkg::pt_byte_t exp;
		logic [msg_bits-1:0] pt;
		logic [msg_bits-1:0] ct;
		int got;
		int start_errors;
		int wait_cyc;
		logic prev_valid;
		key.word = cases[c][24+msg_bits-1 -: 24];
		pt = cases[c][msg_bits-1:0];
		ct = pt ^ rc4_keystream(key.word);               // Encrypt so the DUT can decrypt.
		start_errors = errors;
		for (int k = 0; k < `RC4_MSG_LEN; k++) begin
			@(negedge clk);
			load_i = 1'b1;
			load_idx_i = rc4_pkg::msg_idx_t'(k);
			load_data_i = ct[msg_bits - 1 - 8 * k -: 8];
		end
		@(negedge clk);
		load_i = 1'b0;
		key_i = key;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		load_idx_i = 3;                                  // Stray load aimed at byte 3 mid-run.
		load_data_i = ~ct[msg_bits - 1 - 8 * 3 -: 8];
		got = 0;
		wait_cyc = 0;
		do begin
			prev_valid = pt_o.valid;                     // Sample from one cycle back.
			@(negedge clk);
			wait_cyc++;
			load_i = (wait_cyc == 40);                   // Lands during the initialisation loop.
			if (pt_o.valid) begin
				exp = '{valid: 1'b1, idx: rc4_pkg::msg_idx_t'(got),
					data: pt[msg_bits - 1 - 8 * got -: 8]};
				check_pt(exp, pt_o);
				got++;
			end
		end while (!done_o);
		if (got != `RC4_MSG_LEN || !prev_valid) begin
			$display("Case %0d: done_o rose after %0d strobes, not right after the last one.",
				c, got);
			errors++;
		end
		hold_idle(1'b1);
		if (errors == start_errors) n_pass++;
		$display("Case %0d, key %h: %0d bytes received, %0s", c, key.word, got,
			(errors == start_errors) ? "all match" : "mismatch");
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		start_i = 1'b0;
		key_i = '0;
		load_i = 1'b0;
		load_idx_i = '0;
		load_data_i = '0;
		{n_cases, n_pass, errors, cycles} = '0;
		$readmemh("verif/rc4_cases.txt", cases);
		for (int n = 0; n < max_cases; n++) begin
			if (!$isunknown(cases[n])) n_cases++;
		end
		// Fourteen cycles per generated byte plus margin for loading and idle checks.
		cycle_limit = n_cases * (256 + 2560 + 32 * 16 + 100) + 100;
		if (n_cases == 0) begin
			$display("No test cases were read from verif/rc4_cases.txt.");
			errors++;
		end
		ks_ref = rc4_keystream(24'h4b6579);              // The key "Key".
		if (ks_ref[msg_bits-1 -: 72] !== 72'heb9f7781b734ca72a7) begin
			$display("The reference RC4 model disagrees with the published test vector.");
			errors++;
		end
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		hold_idle(1'b0);                                 // Nothing may happen before a start.
		for (int c = 0; c < n_cases; c++) run_case(c);  // Cases run back to back without a reset.
		if (uut.u_rc4_assert.fail_cnt != 0) begin
			$display("Bound assertions failed %0d times.", uut.u_rc4_assert.fail_cnt);
			errors += uut.u_rc4_assert.fail_cnt;
		end
		$display("Cases passed: %0d, failed: %0d", n_pass, n_cases - n_pass);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* verif/rc4_cases.txt */
// One case per line: 6 hex digits of key, then 64 hex digits of plaintext, byte 0 first.
// The testbench encrypts each line with RC4 and expects the DUT to recover the plaintext.
4b6579506c61696e746578742c207468697274792d74776f206279746573206c6f6e67
6162635365636f6e64206d6573736167652c20646966666572656e74206b6579212121
ffffff0000000000000000000000000000000000000000000000000000000000000000

/* filelist.f */
+incdir+logic
logic/rc4_pkg.sv
logic/sbox_ram.sv
logic/ksa_ctrl.sv
logic/keystream_gen.sv
logic/cipher_store.sv
logic/plain_combine.sv
logic/rc4_top.sv
verif/rc4_assert.sv
verif/rc4_tb.sv

/* Bender.yml */
package:
  name: rc4_decrypt

sources:
  - include_dirs:
      - logic
    files:
      - logic/rc4_pkg.sv
      - logic/sbox_ram.sv
      - logic/ksa_ctrl.sv
      - logic/keystream_gen.sv
      - logic/cipher_store.sv
      - logic/plain_combine.sv
      - logic/rc4_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/rc4_assert.sv
      - verif/rc4_tb.sv
